// ==== common/cluster_periph_defines.svh ====
// Sizes and register map of the cluster peripheral.
// Included by the package and by every RTL file that needs a size or an offset.
`ifndef CLUSTER_PERIPH_DEFINES_SVH
`define CLUSTER_PERIPH_DEFINES_SVH

// Cluster and counter sizes.
`define NR_CORES          4
`define NUM_PERF_COUNTERS 4
`define PERF_CNT_WIDTH    48

// Register bus and DMA widths.
`define REG_ADDR_WIDTH    12
`define REG_DATA_WIDTH    32
`define DMA_DATA_WIDTH    64

// Register offsets, in bytes.
`define PERF_CNT_EN_BASE  12'h000
`define PERF_CNT_SEL_BASE 12'h040
`define PERF_CNT_BASE     12'h080
`define CL_CLINT_SET      12'h100
`define CL_CLINT_CLEAR    12'h104
`define ICACHE_PREFETCH   12'h108

// Reset values.
`define ICACHE_PREFETCH_RST 1'b1

`endif

// ==== common/cluster_periph_pkg.sv ====
// Types shared by the cluster peripheral RTL and its testbench.
// Event vectors are plain bit vectors; the *_EV_* constants name their bits.
`include "cluster_periph_defines.svh"

package cluster_periph_pkg;

  // Register bus.
  typedef logic [`REG_ADDR_WIDTH-1:0]   reg_addr_t;
  typedef logic [`REG_DATA_WIDTH-1:0]   reg_data_t;
  typedef logic [`REG_DATA_WIDTH/8-1:0] reg_strb_t;

  // Counter values and per-cycle increments.
  typedef logic [`PERF_CNT_WIDTH-1:0]   perf_cnt_t;
  typedef logic [7:0]                   perf_inc_t;
  typedef logic [$clog2(`NR_CORES)-1:0] hart_sel_t;

  // Core events, bit 3 is spare.
  typedef logic [3:0] core_events_t;
  localparam int unsigned CORE_EV_RETIRED_INSTR = 0;
  localparam int unsigned CORE_EV_RETIRED_LOAD  = 1;
  localparam int unsigned CORE_EV_ISSUE_FPU     = 2;

  // L0 instruction cache events, bit 2 is prefetch.
  typedef logic [3:0] icache_events_t;
  localparam int unsigned ICACHE_EV_MISS  = 0;
  localparam int unsigned ICACHE_EV_HIT   = 1;
  localparam int unsigned ICACHE_EV_STALL = 3;

  // TCDM events.
  typedef logic [1:0] tcdm_events_t;
  localparam int unsigned TCDM_EV_ACCESSED  = 0;
  localparam int unsigned TCDM_EV_CONGESTED = 1;

  // DMA events, bytes written this cycle in the top byte.
  typedef logic [9:0] dma_events_t;
  localparam int unsigned DMA_EV_BUSY      = 0;
  localparam int unsigned DMA_EV_W_DONE    = 1;
  localparam int unsigned DMA_EV_BYTES_LSB = 2;

  typedef enum logic [3:0] {
    METRIC_CYCLE          = 4'd0,
    METRIC_TCDM_ACCESSED  = 4'd1,
    METRIC_TCDM_CONGESTED = 4'd2,
    METRIC_RETIRED_INSTR  = 4'd3,
    METRIC_RETIRED_LOAD   = 4'd4,
    METRIC_ISSUE_FPU      = 4'd5,
    METRIC_DMA_BUSY       = 4'd6,
    METRIC_DMA_W_DONE     = 4'd7,
    METRIC_DMA_W_BYTES    = 4'd8,
    METRIC_ICACHE_MISS    = 4'd9,
    METRIC_ICACHE_HIT     = 4'd10,
    METRIC_ICACHE_STALL   = 4'd11
  } perf_metric_e;

  // Metrics tracked right after reset, one per counter.
  localparam perf_metric_e PERF_METRIC_RST [`NUM_PERF_COUNTERS] = '{
    METRIC_CYCLE, METRIC_RETIRED_INSTR, METRIC_TCDM_ACCESSED, METRIC_ICACHE_MISS
  };

endpackage

// ==== src/periph_reg_bridge.sv ====
// Register bus slave of the cluster peripheral.
// Runs a setup cycle and an access cycle per request, decodes the block
// ranges and returns the read data of the selected block.
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module periph_reg_bridge (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  input  logic                          req_write_i,
  input  cluster_periph_pkg::reg_addr_t req_addr_i,
  input  cluster_periph_pkg::reg_data_t req_wdata_i,
  input  cluster_periph_pkg::reg_strb_t req_wstrb_i,
  output logic                          rsp_ready_o,
  output cluster_periph_pkg::reg_data_t rsp_rdata_o,
  output logic                          rsp_error_o,
  output logic                          acc_wr_o,
  output logic                          acc_rd_o,
  output cluster_periph_pkg::reg_addr_t acc_addr_o,
  output cluster_periph_pkg::reg_data_t acc_wdata_o,
  output cluster_periph_pkg::reg_strb_t acc_wstrb_o,
  output logic                          ctrl_sel_o,
  output logic                          perf_sel_o,
  input  cluster_periph_pkg::reg_data_t ctrl_rdata_i,
  input  cluster_periph_pkg::reg_data_t perf_rdata_i
);
  import cluster_periph_pkg::*;

  typedef enum logic {
    SETUP,
    ACCESS
  } bridge_state_e;

  bridge_state_e state_q;
  logic          write_q;
  reg_addr_t     addr_q;
  reg_data_t     wdata_q;
  reg_strb_t     wstrb_q;
  logic          ctrl_hit_q;
  logic          perf_hit_q;
  logic          error_q;
  logic          ctrl_hit;
  logic          perf_hit;
  logic          read_only;
  logic          access;

  // True for a word-aligned address inside a block of words.
  function automatic logic in_words(reg_addr_t addr, reg_addr_t base, int unsigned words);
    return (addr >= base) && (addr < base + reg_addr_t'(4 * words)) && (addr[1:0] == 2'b00);
  endfunction

  assign ctrl_hit  = in_words(req_addr_i, `CL_CLINT_SET, 3);
  assign perf_hit  = in_words(req_addr_i, `PERF_CNT_EN_BASE, `NUM_PERF_COUNTERS) ||
                     in_words(req_addr_i, `PERF_CNT_SEL_BASE, `NUM_PERF_COUNTERS) ||
                     in_words(req_addr_i, `PERF_CNT_BASE, 2 * `NUM_PERF_COUNTERS);
  // Counter high words.
  assign read_only = in_words(req_addr_i, `PERF_CNT_BASE, 2 * `NUM_PERF_COUNTERS) &&
                     req_addr_i[2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SETUP;
    end else if (state_q == SETUP && req_valid_i) begin
      state_q <= ACCESS;
    end else begin
      state_q <= SETUP;
    end
  end

  // Setup cycle captures the request and its decode.
  always_ff @(posedge clk_i) begin
    if (state_q == SETUP) begin
      write_q    <= req_write_i;
      addr_q     <= req_addr_i;
      wdata_q    <= req_wdata_i;
      wstrb_q    <= req_wstrb_i;
      ctrl_hit_q <= ctrl_hit;
      perf_hit_q <= perf_hit;
      error_q    <= !(ctrl_hit || perf_hit) || (req_write_i && read_only);
    end
  end

  assign access      = (state_q == ACCESS);
  assign rsp_ready_o = access;
  assign rsp_error_o = access && error_q;
  // Failed writes never reach the blocks.
  assign acc_wr_o    = access && write_q && !error_q;
  assign acc_rd_o    = access && !write_q;
  assign acc_addr_o  = addr_q;
  assign acc_wdata_o = wdata_q;
  assign acc_wstrb_o = wstrb_q;
  assign ctrl_sel_o  = access && ctrl_hit_q;
  assign perf_sel_o  = access && perf_hit_q;

  assign rsp_rdata_o = (acc_rd_o && ctrl_hit_q) ? ctrl_rdata_i :
                       (acc_rd_o && perf_hit_q) ? perf_rdata_i : '0;

  // The response only comes while the master still requests.
  a_ready_with_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_ready_o |-> req_valid_i
  );

endmodule

// ==== src/cluster_ctrl_regs.sv ====
// Cluster control registers: per-core wake-up bits and the icache prefetch
// enable. Writes arrive from the register bridge with their byte strobes.
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module cluster_ctrl_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          sel_i,
  input  logic                          wr_i,
  input  cluster_periph_pkg::reg_addr_t addr_i,
  input  cluster_periph_pkg::reg_data_t wdata_i,
  input  cluster_periph_pkg::reg_strb_t wstrb_i,
  output cluster_periph_pkg::reg_data_t rdata_o,
  output logic [`NR_CORES-1:0]          cl_clint_o,
  output logic                          icache_prefetch_enable_o
);
  import cluster_periph_pkg::*;

  logic [`NR_CORES-1:0] clint_q;
  logic [`NR_CORES-1:0] wr_mask;
  logic                 prefetch_q;
  logic                 we;

  assign we = sel_i && wr_i;

  // Data bits whose byte lane is enabled.
  always_comb begin
    for (int i = 0; i < `NR_CORES; i++) begin
      wr_mask[i] = wstrb_i[i / 8] && wdata_i[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      clint_q    <= '0;
      prefetch_q <= `ICACHE_PREFETCH_RST;
    end else if (we) begin
      if (addr_i == `CL_CLINT_SET) begin
        clint_q <= clint_q | wr_mask;
      end else if (addr_i == `CL_CLINT_CLEAR) begin
        clint_q <= clint_q & ~wr_mask;
      end else if (addr_i == `ICACHE_PREFETCH && wstrb_i[0]) begin
        prefetch_q <= wdata_i[0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (addr_i == `CL_CLINT_SET || addr_i == `CL_CLINT_CLEAR) begin
      rdata_o = reg_data_t'(clint_q);
    end else if (addr_i == `ICACHE_PREFETCH) begin
      rdata_o = reg_data_t'(prefetch_q);
    end
  end

  assign cl_clint_o               = clint_q;
  assign icache_prefetch_enable_o = prefetch_q;

endmodule

// ==== perf/perf_event_sampler.sv ====
// Event sampling for the performance counters.
// Registers the TCDM, DMA and icache events once and maps each counter's
// metric and hart onto a per-cycle increment. Core events are used directly.
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module perf_event_sampler (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  cluster_periph_pkg::core_events_t [`NR_CORES-1:0] core_events_i,
  input  cluster_periph_pkg::tcdm_events_t                 tcdm_events_i,
  input  cluster_periph_pkg::dma_events_t                  dma_events_i,
  input  cluster_periph_pkg::icache_events_t [`NR_CORES-1:0] icache_events_i,
  input  cluster_periph_pkg::perf_metric_e [`NUM_PERF_COUNTERS-1:0] metric_i,
  input  cluster_periph_pkg::hart_sel_t [`NUM_PERF_COUNTERS-1:0]    hart_i,
  output cluster_periph_pkg::perf_inc_t [`NUM_PERF_COUNTERS-1:0]    inc_o
);
  import cluster_periph_pkg::*;

  tcdm_events_t                   tcdm_q;
  dma_events_t                    dma_q;
  icache_events_t [`NR_CORES-1:0] icache_q;

  // Pipeline stage for the events from outside the cores.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tcdm_q   <= '0;
      dma_q    <= '0;
      icache_q <= '0;
    end else begin
      tcdm_q   <= tcdm_events_i;
      dma_q    <= dma_events_i;
      icache_q <= icache_events_i;
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_PERF_COUNTERS; i++) begin
      case (metric_i[i])
        METRIC_CYCLE:          inc_o[i] = perf_inc_t'(1);
        METRIC_TCDM_ACCESSED:  inc_o[i] = perf_inc_t'(tcdm_q[TCDM_EV_ACCESSED]);
        METRIC_TCDM_CONGESTED: inc_o[i] = perf_inc_t'(tcdm_q[TCDM_EV_CONGESTED]);
        METRIC_RETIRED_INSTR:
          inc_o[i] = perf_inc_t'(core_events_i[hart_i[i]][CORE_EV_RETIRED_INSTR]);
        METRIC_RETIRED_LOAD:
          inc_o[i] = perf_inc_t'(core_events_i[hart_i[i]][CORE_EV_RETIRED_LOAD]);
        METRIC_ISSUE_FPU:
          inc_o[i] = perf_inc_t'(core_events_i[hart_i[i]][CORE_EV_ISSUE_FPU]);
        // Single DMA channel, the hart is ignored.
        METRIC_DMA_BUSY:       inc_o[i] = perf_inc_t'(dma_q[DMA_EV_BUSY]);
        METRIC_DMA_W_DONE:     inc_o[i] = perf_inc_t'(dma_q[DMA_EV_W_DONE]);
        METRIC_DMA_W_BYTES:    inc_o[i] = dma_q[DMA_EV_BYTES_LSB +: 8];
        METRIC_ICACHE_MISS:    inc_o[i] = perf_inc_t'(icache_q[hart_i[i]][ICACHE_EV_MISS]);
        METRIC_ICACHE_HIT:     inc_o[i] = perf_inc_t'(icache_q[hart_i[i]][ICACHE_EV_HIT]);
        METRIC_ICACHE_STALL:   inc_o[i] = perf_inc_t'(icache_q[hart_i[i]][ICACHE_EV_STALL]);
        default:               inc_o[i] = '0;
      endcase
    end
  end

  // A DMA beat never writes more bytes than the data bus carries.
  a_dma_bytes_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    dma_events_i[DMA_EV_BYTES_LSB +: 8] <= `DMA_DATA_WIDTH / 8
  );

endmodule

// ==== perf/perf_counter_bank.sv ====
// Performance counter bank with enable, metric and hart select per counter.
// The sampler supplies the increments; software reads and clears the
// counters over the register bridge.
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module perf_counter_bank (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          sel_i,
  input  logic                          wr_i,
  input  cluster_periph_pkg::reg_addr_t addr_i,
  input  cluster_periph_pkg::reg_data_t wdata_i,
  input  cluster_periph_pkg::reg_strb_t wstrb_i,
  output cluster_periph_pkg::reg_data_t rdata_o,
  input  cluster_periph_pkg::perf_inc_t [`NUM_PERF_COUNTERS-1:0]    inc_i,
  output cluster_periph_pkg::perf_metric_e [`NUM_PERF_COUNTERS-1:0] metric_o,
  output cluster_periph_pkg::hart_sel_t [`NUM_PERF_COUNTERS-1:0]    hart_o
);
  import cluster_periph_pkg::*;

  logic         [`NUM_PERF_COUNTERS-1:0] en_q;
  perf_metric_e [`NUM_PERF_COUNTERS-1:0] metric_q;
  hart_sel_t    [`NUM_PERF_COUNTERS-1:0] hart_q;
  perf_cnt_t    [`NUM_PERF_COUNTERS-1:0] cnt_q;
  logic                                  we;

  // Byte address of word idx in a block.
  function automatic reg_addr_t word_addr(reg_addr_t base, int unsigned idx);
    return base + reg_addr_t'(4 * idx);
  endfunction

  assign we = sel_i && wr_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q   <= '0;
      hart_q <= '0;
      cnt_q  <= '0;
      for (int i = 0; i < `NUM_PERF_COUNTERS; i++) begin
        metric_q[i] <= PERF_METRIC_RST[i];
      end
    end else begin
      for (int i = 0; i < `NUM_PERF_COUNTERS; i++) begin
        if (we && addr_i == word_addr(`PERF_CNT_EN_BASE, i) && wstrb_i[0]) begin
          en_q[i] <= wdata_i[0];
        end
        // Metric in byte 0, hart in byte 1.
        if (we && addr_i == word_addr(`PERF_CNT_SEL_BASE, i)) begin
          if (wstrb_i[0]) begin
            metric_q[i] <= perf_metric_e'(wdata_i[3:0]);
          end
          if (wstrb_i[1]) begin
            hart_q[i] <= wdata_i[8 +: $bits(hart_sel_t)];
          end
        end
        // A write to the counter clears it, even while counting.
        if (we && (addr_i == word_addr(`PERF_CNT_BASE, 2 * i) ||
                   addr_i == word_addr(`PERF_CNT_BASE, 2 * i + 1))) begin
          cnt_q[i] <= '0;
        end else if (en_q[i]) begin
          cnt_q[i] <= cnt_q[i] + perf_cnt_t'(inc_i[i]);
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < `NUM_PERF_COUNTERS; i++) begin
      if (addr_i == word_addr(`PERF_CNT_EN_BASE, i)) begin
        rdata_o = reg_data_t'(en_q[i]);
      end else if (addr_i == word_addr(`PERF_CNT_SEL_BASE, i)) begin
        rdata_o = reg_data_t'({hart_q[i], 4'b0000, metric_q[i]});
      end else if (addr_i == word_addr(`PERF_CNT_BASE, 2 * i)) begin
        rdata_o = cnt_q[i][31:0];
      end else if (addr_i == word_addr(`PERF_CNT_BASE, 2 * i + 1)) begin
        rdata_o = reg_data_t'(cnt_q[i][`PERF_CNT_WIDTH-1:32]);
      end
    end
  end

  assign metric_o = metric_q;
  assign hart_o   = hart_q;

  // The sampler indexes the per-core events with this select.
  for (genvar i = 0; i < `NUM_PERF_COUNTERS; i++) begin : gen_hart_check
    a_hart_in_range: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) hart_o[i] < `NR_CORES
    );
  end

endmodule

// ==== src/cluster_peripheral.sv ====
// Cluster peripheral top level.
// Connects the register bridge to the control registers and the counter
// bank, and the counter bank to the event sampler.
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module cluster_peripheral (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  input  logic                          req_write_i,
  input  cluster_periph_pkg::reg_addr_t req_addr_i,
  input  cluster_periph_pkg::reg_data_t req_wdata_i,
  input  cluster_periph_pkg::reg_strb_t req_wstrb_i,
  output logic                          rsp_ready_o,
  output cluster_periph_pkg::reg_data_t rsp_rdata_o,
  output logic                          rsp_error_o,
  output logic [`NR_CORES-1:0]          cl_clint_o,
  output logic                          icache_prefetch_enable_o,
  input  cluster_periph_pkg::core_events_t [`NR_CORES-1:0]   core_events_i,
  input  cluster_periph_pkg::tcdm_events_t                   tcdm_events_i,
  input  cluster_periph_pkg::dma_events_t                    dma_events_i,
  input  cluster_periph_pkg::icache_events_t [`NR_CORES-1:0] icache_events_i
);
  import cluster_periph_pkg::*;

  logic                                  acc_wr;
  reg_addr_t                             acc_addr;
  reg_data_t                             acc_wdata;
  reg_strb_t                             acc_wstrb;
  logic                                  ctrl_sel;
  logic                                  perf_sel;
  reg_data_t                             ctrl_rdata;
  reg_data_t                             perf_rdata;
  perf_metric_e [`NUM_PERF_COUNTERS-1:0] metric;
  hart_sel_t    [`NUM_PERF_COUNTERS-1:0] hart;
  perf_inc_t    [`NUM_PERF_COUNTERS-1:0] inc;

  // Read data is combinational, so no block needs the read strobe.
  periph_reg_bridge i_bridge (
    .clk_i, .rst_n_i, .req_valid_i, .req_write_i, .req_addr_i, .req_wdata_i,
    .req_wstrb_i, .rsp_ready_o, .rsp_rdata_o, .rsp_error_o,
    .acc_wr_o     (acc_wr),
    .acc_rd_o     (),
    .acc_addr_o   (acc_addr),
    .acc_wdata_o  (acc_wdata),
    .acc_wstrb_o  (acc_wstrb),
    .ctrl_sel_o   (ctrl_sel),
    .perf_sel_o   (perf_sel),
    .ctrl_rdata_i (ctrl_rdata),
    .perf_rdata_i (perf_rdata)
  );

  cluster_ctrl_regs i_ctrl_regs (
    .clk_i, .rst_n_i,
    .sel_i   (ctrl_sel),
    .wr_i    (acc_wr),
    .addr_i  (acc_addr),
    .wdata_i (acc_wdata),
    .wstrb_i (acc_wstrb),
    .rdata_o (ctrl_rdata),
    .cl_clint_o, .icache_prefetch_enable_o
  );

  perf_event_sampler i_sampler (
    .clk_i, .rst_n_i, .core_events_i, .tcdm_events_i, .dma_events_i, .icache_events_i,
    .metric_i (metric),
    .hart_i   (hart),
    .inc_o    (inc)
  );

  perf_counter_bank i_counters (
    .clk_i, .rst_n_i,
    .sel_i    (perf_sel),
    .wr_i     (acc_wr),
    .addr_i   (acc_addr),
    .wdata_i  (acc_wdata),
    .wstrb_i  (acc_wstrb),
    .rdata_o  (perf_rdata),
    .inc_i    (inc),
    .metric_o (metric),
    .hart_o   (hart)
  );

endmodule

// ==== sim/tb_cluster_peripheral.sv ====
// Directed testbench for the cluster peripheral.
// Drives the register bus and the event inputs, and checks read-back data,
// wake-up outputs and counter values against expected values kept here.
`timescale 1ns/1ps
`include "cluster_periph_defines.svh"

module tb_cluster_peripheral;
  import cluster_periph_pkg::*;

  localparam int unsigned CLK_PERIOD    = 8;
  localparam int unsigned CORE_CYCLES   = 64;
  localparam int unsigned PIPE_CYCLES   = 48;
  localparam int unsigned BUS_TRANSFERS = 48;
  // The budget allows four cycles per bus transfer and is then doubled.
  localparam int unsigned WATCHDOG_NS   =
    2 * CLK_PERIOD * (CORE_CYCLES + PIPE_CYCLES + 4 * BUS_TRANSFERS + 32);

  localparam perf_metric_e RESET_METRICS [`NUM_PERF_COUNTERS] = '{
    METRIC_CYCLE, METRIC_RETIRED_INSTR, METRIC_TCDM_ACCESSED, METRIC_ICACHE_MISS
  };

  logic                           clk;
  logic                           rst_n;
  logic                           req_valid;
  logic                           req_write;
  reg_addr_t                      req_addr;
  reg_data_t                      req_wdata;
  reg_strb_t                      req_wstrb;
  logic                           rsp_ready;
  reg_data_t                      rsp_rdata;
  logic                           rsp_error;
  logic [`NR_CORES-1:0]           cl_clint;
  logic                           icache_prefetch_enable;
  core_events_t [`NR_CORES-1:0]   core_events;
  tcdm_events_t                   tcdm_events;
  dma_events_t                    dma_events;
  icache_events_t [`NR_CORES-1:0] icache_events;

  logic [31:0] lfsr_state;
  int unsigned error_count;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned errors_in_test;
  perf_cnt_t   hit_count_saved;

  cluster_peripheral UUT (
    .clk_i                    (clk),
    .rst_n_i                  (rst_n),
    .req_valid_i              (req_valid),
    .req_write_i              (req_write),
    .req_addr_i               (req_addr),
    .req_wdata_i              (req_wdata),
    .req_wstrb_i              (req_wstrb),
    .rsp_ready_o              (rsp_ready),
    .rsp_rdata_o              (rsp_rdata),
    .rsp_error_o              (rsp_error),
    .cl_clint_o               (cl_clint),
    .icache_prefetch_enable_o (icache_prefetch_enable),
    .core_events_i            (core_events),
    .tcdm_events_i            (tcdm_events),
    .dma_events_i             (dma_events),
    .icache_events_i          (icache_events)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1. One step per bit.
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(int unsigned n);
    logic [7:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      value = {value[6:0], rand_bit()};
    end
    return value;
  endfunction

  function automatic reg_addr_t en_addr(int unsigned idx);
    return `PERF_CNT_EN_BASE + reg_addr_t'(4 * idx);
  endfunction

  function automatic reg_addr_t sel_addr(int unsigned idx);
    return `PERF_CNT_SEL_BASE + reg_addr_t'(4 * idx);
  endfunction

  function automatic reg_addr_t cnt_addr(int unsigned idx, int unsigned high);
    return `PERF_CNT_BASE + reg_addr_t'(8 * idx + 4 * high);
  endfunction

  // Metric in byte 0, hart in byte 1.
  function automatic reg_data_t sel_word(int unsigned hart, perf_metric_e metric);
    return (reg_data_t'(hart) << 8) | reg_data_t'(metric);
  endfunction

  task automatic check_data(string name, reg_data_t got, reg_data_t exp);
    check_count++;
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      errors_in_test++;
    end
  endtask

  task automatic check_clint(string name, logic [`NR_CORES-1:0] got,
                             logic [`NR_CORES-1:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      errors_in_test++;
    end
  endtask

  task automatic check_error(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      errors_in_test++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
      error_count++;
      errors_in_test++;
    end
  endtask

  // Runs one transfer and samples the response on the falling edge.
  task automatic bus_access(logic write, reg_addr_t addr, reg_data_t wdata,
                            reg_strb_t wstrb, output reg_data_t rdata,
                            output logic error);
    int unsigned waited;
    waited = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wdata <= wdata;
    req_wstrb <= wstrb;
    @(negedge clk);
    while (!rsp_ready && waited < 8) begin
      waited++;
      @(negedge clk);
    end
    check_count++;
    if (!rsp_ready) begin
      $display("The bus gave no response for address 0x%h", addr);
      error_count++;
      errors_in_test++;
    end else if (waited != 1) begin
      // Setup takes one cycle and ready comes in the access cycle.
      $display("The bus answered address 0x%h after %0d cycles instead of 2",
               addr, waited + 1);
      error_count++;
      errors_in_test++;
    end
    rdata = rsp_rdata;
    error = rsp_error;
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic reg_write(reg_addr_t addr, reg_data_t wdata, reg_strb_t wstrb,
                           logic exp_error = 1'b0);
    reg_data_t rdata;
    logic      error;
    bus_access(1'b1, addr, wdata, wstrb, rdata, error);
    check_error($sformatf("rsp_error_o on write to 0x%h", addr), error, exp_error);
  endtask

  task automatic reg_read(reg_addr_t addr, output reg_data_t rdata,
                          input logic exp_error = 1'b0);
    logic error;
    bus_access(1'b0, addr, '0, '0, rdata, error);
    check_error($sformatf("rsp_error_o on read from 0x%h", addr), error, exp_error);
  endtask

  task automatic check_counter(int unsigned idx, perf_cnt_t exp);
    reg_data_t word;
    reg_read(cnt_addr(idx, 0), word);
    check_data($sformatf("counter %0d low word", idx), word, exp[31:0]);
    reg_read(cnt_addr(idx, 1), word);
    check_data($sformatf("counter %0d high word", idx), word,
               reg_data_t'(exp[`PERF_CNT_WIDTH-1:32]));
  endtask

  task automatic report_test(string name);
    test_count++;
    if (errors_in_test == 0) begin
      $display("%-24s ok", name);
    end else begin
      $display("%-24s %0d errors", name, errors_in_test);
    end
    errors_in_test = 0;
  endtask

  task automatic reset_state();
    reg_data_t data;
    for (int unsigned i = 0; i < `NUM_PERF_COUNTERS; i++) begin
      reg_read(sel_addr(i), data);
      check_data($sformatf("counter %0d select", i), data, sel_word(0, RESET_METRICS[i]));
      reg_read(en_addr(i), data);
      check_data($sformatf("counter %0d enable", i), data, '0);
    end
    @(negedge clk);
    check_clint("cl_clint_o", cl_clint, '0);
    check_flag("icache_prefetch_enable_o", icache_prefetch_enable, 1'b1);
    reg_write(`ICACHE_PREFETCH, 32'h0, 4'h1);
    @(negedge clk);
    check_flag("icache_prefetch_enable_o", icache_prefetch_enable, 1'b0);
    report_test("reset state");
  endtask

  task automatic wakeup_set_clear();
    reg_data_t            data;
    logic [`NR_CORES-1:0] clint_exp;
    clint_exp = '0;
    reg_write(`CL_CLINT_SET, 32'h0000_000B, 4'hF);
    clint_exp = clint_exp | 4'hB;
    @(negedge clk);
    check_clint("cl_clint_o after set", cl_clint, clint_exp);
    reg_write(`CL_CLINT_CLEAR, 32'h0000_0009, 4'h1);
    clint_exp = clint_exp & ~4'h9;
    @(negedge clk);
    check_clint("cl_clint_o after clear", cl_clint, clint_exp);
    // No byte enabled, so nothing changes.
    reg_write(`CL_CLINT_SET, 32'h0000_000F, 4'h0);
    @(negedge clk);
    check_clint("cl_clint_o after empty write", cl_clint, clint_exp);
    reg_read(`CL_CLINT_SET, data);
    check_data("wake-up read-back", data, reg_data_t'(clint_exp));
    report_test("wake-up set and clear");
  endtask

  task automatic core_metric_count();
    core_events_t [`NR_CORES-1:0] next_core;
    perf_cnt_t                    exp;
    exp = '0;
    reg_write(sel_addr(1), sel_word(2, METRIC_RETIRED_INSTR), 4'h3);
    reg_write(cnt_addr(1, 0), 32'h0, 4'hF);
    reg_write(en_addr(1), 32'h1, 4'h1);
    for (int unsigned n = 0; n < CORE_CYCLES; n++) begin
      for (int unsigned c = 0; c < `NR_CORES; c++) begin
        next_core[c] = {3'b000, rand_bit()};
      end
      exp = exp + perf_cnt_t'(next_core[2][0]);
      @(posedge clk);
      core_events <= next_core;
    end
    @(posedge clk);
    core_events <= '0;
    repeat (3) @(posedge clk);
    reg_write(en_addr(1), 32'h0, 4'h1);
    check_counter(1, exp);
    report_test("core metric");
  endtask

  task automatic pipelined_metric_count();
    icache_events_t [`NR_CORES-1:0] next_icache;
    logic [7:0]                     bytes;
    perf_cnt_t                      hit_exp;
    perf_cnt_t                      bytes_exp;
    hit_exp   = '0;
    bytes_exp = '0;
    reg_write(sel_addr(2), sel_word(1, METRIC_ICACHE_HIT), 4'h3);
    reg_write(sel_addr(3), sel_word(0, METRIC_DMA_W_BYTES), 4'h1);
    reg_write(cnt_addr(2, 0), 32'h0, 4'hF);
    reg_write(cnt_addr(3, 0), 32'h0, 4'hF);
    reg_write(en_addr(2), 32'h1, 4'h1);
    reg_write(en_addr(3), 32'h1, 4'h1);
    for (int unsigned n = 0; n < PIPE_CYCLES; n++) begin
      for (int unsigned c = 0; c < `NR_CORES; c++) begin
        next_icache[c] = {2'b00, rand_bit(), 1'b0};
      end
      // No more than the 8 bytes of one 64-bit beat.
      bytes     = rand_bits(3) + rand_bits(1);
      hit_exp   = hit_exp + perf_cnt_t'(next_icache[1][1]);
      bytes_exp = bytes_exp + perf_cnt_t'(bytes);
      @(posedge clk);
      icache_events <= next_icache;
      dma_events    <= {bytes, 2'b00};
    end
    @(posedge clk);
    icache_events <= '0;
    dma_events    <= '0;
    repeat (3) @(posedge clk);
    reg_write(en_addr(2), 32'h0, 4'h1);
    reg_write(en_addr(3), 32'h0, 4'h1);
    check_counter(2, hit_exp);
    check_counter(3, bytes_exp);
    hit_count_saved = hit_exp;
    report_test("pipelined metrics");
  endtask

  task automatic partial_strobe_writes();
    reg_data_t data;
    // Byte 0 carries CYCLE but its strobe is off.
    reg_write(sel_addr(1), sel_word(3, METRIC_CYCLE), 4'h2);
    reg_read(sel_addr(1), data);
    check_data("counter 1 select", data, sel_word(3, METRIC_RETIRED_INSTR));
    reg_write(cnt_addr(1, 0), 32'hFFFF_FFFF, 4'hF);
    check_counter(1, '0);
    report_test("partial strobe writes");
  endtask

  task automatic error_responses();
    reg_data_t data;
    reg_read(12'h1F0, data, 1'b1);
    reg_write(cnt_addr(2, 1), 32'h0, 4'hF, 1'b1);
    check_counter(2, hit_count_saved);
    report_test("error responses");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    lfsr_state     = 32'd87244;
    error_count    = 0;
    check_count    = 0;
    test_count     = 0;
    errors_in_test = 0;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_write      = 1'b0;
    req_addr       = '0;
    req_wdata      = '0;
    req_wstrb      = '0;
    core_events    = '0;
    tcdm_events    = '0;
    dma_events     = '0;
    icache_events  = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    reset_state();
    wakeup_set_clear();
    core_metric_count();
    pipelined_metric_count();
    partial_strobe_writes();
    error_responses();
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+common
common/cluster_periph_pkg.sv
src/periph_reg_bridge.sv
src/cluster_ctrl_regs.sv
perf/perf_event_sampler.sv
perf/perf_counter_bank.sv
src/cluster_peripheral.sv
sim/tb_cluster_peripheral.sv

// ==== Makefile ====
SRCS := $(wildcard common/*.sv common/*.svh src/*.sv perf/*.sv sim/*.sv)

obj_dir/Vtb_cluster_peripheral: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cluster_peripheral \
	  -f sim.f -o Vtb_cluster_peripheral

run: obj_dir/Vtb_cluster_peripheral
	obj_dir/Vtb_cluster_peripheral | tee sim.log
	grep -q "SIMULATION PASSED" sim.log && ! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
